// File: hw/mpmc_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "mpmc_settings.svh"

module mpmc_fifo
#(
	parameter type payload_t = logic [`MPMC_DATA_W-1:0]
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t head,
	output logic     empty,
	output logic     full,
	output logic     rst_busy
);

	localparam int DEPTH = `MPMC_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int BUSY_W = $clog2(`MPMC_FIFO_RST_CYCLES + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [BUSY_W-1:0] busy_cnt;
	logic do_push;
	logic do_pop;

	// ==============================
	// Reset busy window
	// ==============================

	// The queue reports busy for a few cycles once reset is released
	always_ff @(posedge clk)
	begin
		if (rst)
			busy_cnt <= BUSY_W'(`MPMC_FIFO_RST_CYCLES);
		else if (busy_cnt != '0)
			busy_cnt <= busy_cnt - 1'b1;
	end

	assign rst_busy = (busy_cnt != '0);

	// ==============================
	// Circular buffer
	// ==============================

	// Pushes are dropped while the queue is still coming out of reset
	assign do_push = push && !full && !rst_busy;
	assign do_pop = pop && !empty;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Count moves only when exactly one side is active
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Storage holds payload only and is never cleared
	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	// First word fall through, the head is visible while the queue is not empty
	assign head = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));

	// Producer honours the full flag
	a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full)
		else $error("mpmc_fifo: push while full");

	// Consumer only pops a queue that holds data
	a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
		else $error("mpmc_fifo: pop while empty");

endmodule

`default_nettype wire

// File: hw/mpmc_mem_array.sv
`default_nettype none
`timescale 1ns/1ps

`include "mpmc_settings.svh"

module mpmc_mem_array
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    mem_rd,
	input  logic                    mem_wr,
	input  logic [`MPMC_ADDR_W-1:0] mem_addr,
	input  logic [`MPMC_DATA_W-1:0] mem_wdata,
	output logic [`MPMC_DATA_W-1:0] mem_rdata,
	output logic                    mem_rvalid,
	output logic                    calib_complete
);

	localparam int WORDS = 2 ** `MPMC_ADDR_W;
	localparam int LAT = `MPMC_RD_LATENCY;
	localparam int CAL_W = $clog2(`MPMC_CALIB_CYCLES + 1);

	logic [`MPMC_DATA_W-1:0] mem [WORDS];
	logic [CAL_W-1:0] cal_cnt;
	logic [LAT-1:0] rvalid_pipe;
	logic [`MPMC_DATA_W-1:0] rdata_pipe [LAT];

	// ==============================
	// Calibration
	// ==============================

	// Counts up once after reset and stops when calibration is reported
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cal_cnt <= '0;
			calib_complete <= 1'b0;
		end
		else if (!calib_complete)
		begin
			cal_cnt <= cal_cnt + 1'b1;
			calib_complete <= (cal_cnt == CAL_W'(`MPMC_CALIB_CYCLES - 1));
		end
	end

	// ==============================
	// Array and read pipeline
	// ==============================

	// Writes land at the edge that samples the strobe
	always_ff @(posedge clk)
	begin
		if (mem_wr)
			mem[mem_addr] <= mem_wdata;
	end

	// Valid bits are control and get cleared
	always_ff @(posedge clk)
	begin
		if (rst)
			rvalid_pipe <= '0;
		else
		begin
			rvalid_pipe[0] <= mem_rd;
			for (int i = 1; i < LAT; i++)
				rvalid_pipe[i] <= rvalid_pipe[i-1];
		end
	end

	// Data stages just follow along behind the valid bits
	always_ff @(posedge clk)
	begin
		rdata_pipe[0] <= mem[mem_addr];
		for (int i = 1; i < LAT; i++)
			rdata_pipe[i] <= rdata_pipe[i-1];
	end

	assign mem_rvalid = rvalid_pipe[LAT-1];
	assign mem_rdata = rdata_pipe[LAT-1];

	// The pop strobe generator holds every command back until calibration ends
	a_no_early_access: assert property (@(posedge clk) disable iff (rst)
		(mem_rd || mem_wr) |-> calib_complete)
		else $error("mpmc_mem_array: access before calibration");

endmodule

`default_nettype wire

// File: hw/mpmc_pkg.sv
`default_nettype none

`include "mpmc_settings.svh"

package mpmc_pkg;

	// ==============================
	// Sequencer states
	// ==============================

	// IDLE waits for the pop strobe, ACCEPT holds the command until a read
	// has room in its response queue, ISSUE drives the memory for one cycle
	// and WAIT_DATA covers the read latency
	typedef enum logic [1:0]
	{
		IDLE      = 2'd0,
		ACCEPT    = 2'd1,
		ISSUE     = 2'd2,
		WAIT_DATA = 2'd3
	} mpmc_state_t;

	// ==============================
	// Command word
	// ==============================

	// One entry of a command queue
	// The write data field is ignored for reads
	typedef struct packed
	{
		logic                    we;
		logic [`MPMC_ADDR_W-1:0] addr;
		logic [`MPMC_DATA_W-1:0] wdata;
	} mpmc_cmd_t;

endpackage

`default_nettype wire

// File: hw/mpmc_port_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

`include "mpmc_settings.svh"

module mpmc_port_arbiter
(
	input  logic                           clk,
	input  logic                           rst,
	input  logic [`MPMC_NUM_PORTS-1:0]     empty_vec,
	input  logic [`MPMC_NUM_PORTS-1:0]     rst_busy_vec,
	input  mpmc_pkg::mpmc_cmd_t            cmd_vec [`MPMC_NUM_PORTS],
	input  logic                           rd,
	output logic [`MPMC_PORT_W-1:0]        grant,
	output logic                           grant_empty,
	output mpmc_pkg::mpmc_cmd_t            grant_cmd,
	output logic                           grant_rst_busy
);

	localparam int NUM_PORTS = `MPMC_NUM_PORTS;

	logic [`MPMC_PORT_W-1:0] next_grant;

	// ==============================
	// Round-robin search
	// ==============================

	// Look at the other ports in order, starting just after the current one
	// When none of them holds a command the grant stays where it is
	always_comb
	begin
		int idx;
		logic found;
		next_grant = grant;
		found = 1'b0;
		for (int i = 1; i < NUM_PORTS; i++)
		begin
			idx = (int'(grant) + i) % NUM_PORTS;
			if (!found && !empty_vec[idx])
			begin
				next_grant = `MPMC_PORT_W'(idx);
				found = 1'b1;
			end
		end
	end

	// Rotate after every pop, and also move off an idle port when another waits
	// A granted port with data is kept until its command is popped
	always_ff @(posedge clk)
	begin
		if (rst)
			grant <= '0;
		else if (rd || empty_vec[grant])
			grant <= next_grant;
	end

	// Head, empty and busy of the granted queue
	assign grant_empty = empty_vec[grant];
	assign grant_rst_busy = rst_busy_vec[grant];
	assign grant_cmd = cmd_vec[grant];

	// The pop strobe was raised against this grant, so it must not have moved
	a_grant_stable: assert property (@(posedge clk) disable iff (rst) rd |-> $stable(grant))
		else $error("mpmc_port_arbiter: grant changed under the pop strobe");

endmodule

`default_nettype wire

// File: hw/mpmc_rd_fifo_gen.sv
`default_nettype none
`timescale 1ns/1ps

module mpmc_rd_fifo_gen
(
	input  logic                  clk,
	input  logic                  rst,
	input  mpmc_pkg::mpmc_state_t state,
	input  logic                  empty,
	input  logic                  rd_rst_busy,
	input  logic                  calib_complete,
	output logic                  rd
);

	logic rd_next;

	// Only an idle sequencer may take a command
	// The granted queue must hold data, be out of reset, and the memory must be calibrated
	always_comb
	begin
		rd_next = 1'b0;
		if (state == mpmc_pkg::IDLE)
		begin
			rd_next = rd;
			if (!empty && !rd_rst_busy && calib_complete)
				rd_next = 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			rd <= 1'b0;
		else
			rd <= rd_next;
	end

	// The sequencer leaves IDLE on the pop, so the strobe never lasts two cycles
	a_rd_single: assert property (@(posedge clk) disable iff (rst) rd |=> !rd)
		else $error("mpmc_rd_fifo_gen: pop strobe held for more than one cycle");

endmodule

`default_nettype wire

// File: hw/mpmc_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

`include "mpmc_settings.svh"

module mpmc_sequencer
(
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       rd,
	input  logic [`MPMC_PORT_W-1:0]    grant,
	input  mpmc_pkg::mpmc_cmd_t        grant_cmd,
	input  logic [`MPMC_NUM_PORTS-1:0] resp_full_vec,
	input  logic                       mem_rvalid,
	input  logic [`MPMC_DATA_W-1:0]    mem_rdata,
	output mpmc_pkg::mpmc_state_t      state,
	output logic                       mem_rd,
	output logic                       mem_wr,
	output logic [`MPMC_ADDR_W-1:0]    mem_addr,
	output logic [`MPMC_DATA_W-1:0]    mem_wdata,
	output logic [`MPMC_NUM_PORTS-1:0] resp_push_vec,
	output logic [`MPMC_DATA_W-1:0]    resp_data
);

	mpmc_pkg::mpmc_state_t state_q;
	mpmc_pkg::mpmc_state_t state_next;
	mpmc_pkg::mpmc_cmd_t cmd_q;
	logic [`MPMC_PORT_W-1:0] port_q;

	// ==============================
	// State machine
	// ==============================

	always_comb
	begin
		state_next = state_q;
		case (state_q)
			mpmc_pkg::IDLE:
				if (rd)
					state_next = mpmc_pkg::ACCEPT;
			// A read needs a free slot in its response queue before it goes out
			mpmc_pkg::ACCEPT:
				if (cmd_q.we || !resp_full_vec[port_q])
					state_next = mpmc_pkg::ISSUE;
			mpmc_pkg::ISSUE:
				state_next = cmd_q.we ? mpmc_pkg::IDLE : mpmc_pkg::WAIT_DATA;
			mpmc_pkg::WAIT_DATA:
				if (mem_rvalid)
					state_next = mpmc_pkg::IDLE;
			default:
				state_next = mpmc_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			state_q <= mpmc_pkg::IDLE;
		else
			state_q <= state_next;
	end

	// The pop strobe generator sees the next state
	// That way it drops the strobe in the same cycle the command is taken
	assign state = state_next;

	// Capture the popped command and the port it came from
	always_ff @(posedge clk)
	begin
		if (state_q == mpmc_pkg::IDLE && rd)
		begin
			cmd_q <= grant_cmd;
			port_q <= grant;
		end
	end

	// ==============================
	// Memory and response side
	// ==============================

	// One cycle strobe towards the memory while in ISSUE
	assign mem_wr = (state_q == mpmc_pkg::ISSUE) && cmd_q.we;
	assign mem_rd = (state_q == mpmc_pkg::ISSUE) && !cmd_q.we;
	assign mem_addr = cmd_q.addr;
	assign mem_wdata = cmd_q.wdata;

	// Read data goes back to the port that issued the command
	always_comb
	begin
		resp_push_vec = '0;
		if (state_q == mpmc_pkg::WAIT_DATA && mem_rvalid)
			resp_push_vec[port_q] = 1'b1;
	end

	assign resp_data = mem_rdata;

	// Only one read is ever outstanding, and its data is expected here
	a_rvalid_in_wait: assert property (@(posedge clk) disable iff (rst)
		mem_rvalid |-> state_q == mpmc_pkg::WAIT_DATA)
		else $error("mpmc_sequencer: read data outside WAIT_DATA");

endmodule

`default_nettype wire

// File: hw/mpmc_settings.svh
`ifndef MPMC_SETTINGS_SVH
`define MPMC_SETTINGS_SVH

// Number of client ports sharing the memory
`define MPMC_NUM_PORTS 2
// Width of a port index, as carried by the grant
`define MPMC_PORT_W $clog2(`MPMC_NUM_PORTS)

// Word address width, 64 words in the array
`define MPMC_ADDR_W 6
`define MPMC_DATA_W 32

// Entries in every command and response queue
`define MPMC_FIFO_DEPTH 4
// Queues stay busy this many cycles after reset is released
`define MPMC_FIFO_RST_CYCLES 4

// Memory model timing, calibration after reset and read latency
`define MPMC_CALIB_CYCLES 20
`define MPMC_RD_LATENCY 2

`endif

// File: hw/mpmc_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "mpmc_settings.svh"

module mpmc_top
(
	input  logic                       clk,
	input  logic                       rst,
	input  logic [`MPMC_NUM_PORTS-1:0] req_push,
	input  logic [`MPMC_NUM_PORTS-1:0] req_we,
	input  logic [`MPMC_ADDR_W-1:0]    req_addr [`MPMC_NUM_PORTS],
	input  logic [`MPMC_DATA_W-1:0]    req_wdata [`MPMC_NUM_PORTS],
	output logic [`MPMC_NUM_PORTS-1:0] req_full,
	output logic [`MPMC_NUM_PORTS-1:0] resp_valid,
	output logic [`MPMC_DATA_W-1:0]    resp_data [`MPMC_NUM_PORTS],
	input  logic [`MPMC_NUM_PORTS-1:0] resp_pop,
	output logic                       calib_complete
);

	// Command queue side
	logic [`MPMC_NUM_PORTS-1:0] cmd_empty;
	logic [`MPMC_NUM_PORTS-1:0] cmd_rst_busy;
	logic [`MPMC_NUM_PORTS-1:0] cmd_pop;
	mpmc_pkg::mpmc_cmd_t cmd_head [`MPMC_NUM_PORTS];

	// Response queue side
	logic [`MPMC_NUM_PORTS-1:0] resp_empty;
	logic [`MPMC_NUM_PORTS-1:0] resp_full;
	logic [`MPMC_NUM_PORTS-1:0] resp_push;
	logic [`MPMC_DATA_W-1:0] resp_wdata;

	// Arbitration and sequencing
	logic [`MPMC_PORT_W-1:0] grant;
	logic grant_empty;
	logic grant_rst_busy;
	mpmc_pkg::mpmc_cmd_t grant_cmd;
	logic rd;
	mpmc_pkg::mpmc_state_t state;

	// Memory interface
	logic mem_rd;
	logic mem_wr;
	logic [`MPMC_ADDR_W-1:0] mem_addr;
	logic [`MPMC_DATA_W-1:0] mem_wdata;
	logic [`MPMC_DATA_W-1:0] mem_rdata;
	logic mem_rvalid;

	// ==============================
	// Per-port queues
	// ==============================

	for (genvar p = 0; p < `MPMC_NUM_PORTS; p++)
	begin : g_port
		// The pop strobe only reaches the granted queue
		assign cmd_pop[p] = rd && (grant == `MPMC_PORT_W'(p));

		mpmc_fifo #(.payload_t(mpmc_pkg::mpmc_cmd_t)) u_cmd_fifo
		(
			.clk       (clk),
			.rst       (rst),
			.push      (req_push[p]),
			.push_data ({req_we[p], req_addr[p], req_wdata[p]}),
			.pop       (cmd_pop[p]),
			.head      (cmd_head[p]),
			.empty     (cmd_empty[p]),
			.full      (req_full[p]),
			.rst_busy  (cmd_rst_busy[p])
		);

		// Read data waits here until the client pops it
		mpmc_fifo #(.payload_t(logic [`MPMC_DATA_W-1:0])) u_resp_fifo
		(
			.clk       (clk),
			.rst       (rst),
			.push      (resp_push[p]),
			.push_data (resp_wdata),
			.pop       (resp_pop[p]),
			.head      (resp_data[p]),
			.empty     (resp_empty[p]),
			.full      (resp_full[p]),
			.rst_busy  ()
		);

		assign resp_valid[p] = !resp_empty[p];
	end

	// ==============================
	// Shared datapath
	// ==============================

	mpmc_port_arbiter u_arbiter
	(
		.clk            (clk),
		.rst            (rst),
		.empty_vec      (cmd_empty),
		.rst_busy_vec   (cmd_rst_busy),
		.cmd_vec        (cmd_head),
		.rd             (rd),
		.grant          (grant),
		.grant_empty    (grant_empty),
		.grant_cmd      (grant_cmd),
		.grant_rst_busy (grant_rst_busy)
	);

	mpmc_rd_fifo_gen u_rd_gen
	(
		.clk            (clk),
		.rst            (rst),
		.state          (state),
		.empty          (grant_empty),
		.rd_rst_busy    (grant_rst_busy),
		.calib_complete (calib_complete),
		.rd             (rd)
	);

	mpmc_sequencer u_sequencer
	(
		.clk           (clk),
		.rst           (rst),
		.rd            (rd),
		.grant         (grant),
		.grant_cmd     (grant_cmd),
		.resp_full_vec (resp_full),
		.mem_rvalid    (mem_rvalid),
		.mem_rdata     (mem_rdata),
		.state         (state),
		.mem_rd        (mem_rd),
		.mem_wr        (mem_wr),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.resp_push_vec (resp_push),
		.resp_data     (resp_wdata)
	);

	mpmc_mem_array u_mem
	(
		.clk            (clk),
		.rst            (rst),
		.mem_rd         (mem_rd),
		.mem_wr         (mem_wr),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.mem_rdata      (mem_rdata),
		.mem_rvalid     (mem_rvalid),
		.calib_complete (calib_complete)
	);

endmodule

`default_nettype wire

// File: mpmc_lite.f
+incdir+hw
hw/mpmc_pkg.sv
hw/mpmc_fifo.sv
hw/mpmc_port_arbiter.sv
hw/mpmc_rd_fifo_gen.sv
hw/mpmc_sequencer.sv
hw/mpmc_mem_array.sv
hw/mpmc_top.sv
verification/mpmc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the mpmc_lite testbench with Verilator and runs it
# The pass line in the simulation log decides the result

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module mpmc_tb -Mdir "$BUILD_DIR" -f mpmc_lite.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vmpmc_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
fi

if grep -qx "all tests passed" "$LOG_FILE"; then
	echo "Result PASS"
	exit 0
else
	echo "Result FAIL, see $LOG_FILE"
	exit 1
fi

// File: verification/mpmc_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "mpmc_settings.svh"

module mpmc_tb;

	localparam int NUM_PORTS = `MPMC_NUM_PORTS;
	localparam int ADDR_W = `MPMC_ADDR_W;
	localparam int DATA_W = `MPMC_DATA_W;
	localparam int WORDS = 2 ** ADDR_W;
	// Each port owns one half of the address space in the random traffic
	localparam int HALF_W = ADDR_W - 1;
	localparam int RESET_CYCLES = 5;
	// Four reads take about five cycles each to land in a response queue
	localparam int STALL_CYCLES = 32;
	// The tests need well under a thousand cycles together
	localparam int TIMEOUT_CYCLES = 3000;

	logic clk = 1'b0;
	logic rst;
	logic [NUM_PORTS-1:0] req_push;
	logic [NUM_PORTS-1:0] req_we;
	logic [ADDR_W-1:0] req_addr [NUM_PORTS];
	logic [DATA_W-1:0] req_wdata [NUM_PORTS];
	logic [NUM_PORTS-1:0] req_full;
	logic [NUM_PORTS-1:0] resp_valid;
	logic [DATA_W-1:0] resp_data [NUM_PORTS];
	logic [NUM_PORTS-1:0] resp_pop;
	logic calib_complete;

	// Shadow of the memory contents that is updated in push order
	logic [DATA_W-1:0] shadow [WORDS];
	// Read data each port still waits for with the oldest first
	logic [DATA_W-1:0] exp_q [NUM_PORTS][$];
	// Value the response head must show while resp_pop is high
	logic [DATA_W-1:0] exp_data [NUM_PORTS];
	logic [NUM_PORTS-1:0] full_expect;
	logic [31:0] lcg_state;
	int cycle_cnt = 0;

	mpmc_top dut0
	(
		.clk            (clk),
		.rst            (rst),
		.req_push       (req_push),
		.req_we         (req_we),
		.req_addr       (req_addr),
		.req_wdata      (req_wdata),
		.req_full       (req_full),
		.resp_valid     (resp_valid),
		.resp_data      (resp_data),
		.resp_pop       (resp_pop),
		.calib_complete (calib_complete)
	);

	always #50 clk = ~clk;

	// ==============================
	// Helpers
	// ==============================

	task automatic stop_on_error();
		$display("tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int outstanding();
		int total;
		total = 0;
		for (int p = 0; p < NUM_PORTS; p++)
			total += exp_q[p].size();
		return total;
	endfunction

	// Inputs move 10 ns after the rising edge and strobes last one cycle
	task automatic next_cycle();
		@(posedge clk);
		#10;
		req_push = '0;
		resp_pop = '0;
	endtask

	task automatic stage_push(input int p, input logic we, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		req_push[p] = 1'b1;
		req_we[p] = we;
		req_addr[p] = addr;
		req_wdata[p] = data;
		// A read returns whatever the last earlier write to that address left
		if (we)
			shadow[addr] = data;
		else
			exp_q[p].push_back(shadow[addr]);
	endtask

	task automatic push_cmd(input int p, input logic we, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		while (req_full[p])
			next_cycle();
		stage_push(p, we, addr, data);
		next_cycle();
	endtask

	task automatic stage_pop(input int p);
		if (exp_q[p].size() == 0)
		begin
			$display("ERROR: port %0d returned data with no read outstanding", p);
			stop_on_error();
		end
		else
		begin
			exp_data[p] = exp_q[p].pop_front();
			resp_pop[p] = 1'b1;
		end
	endtask

	// Pops one port until every read it issued has come back
	task automatic drain(input int p);
		while (exp_q[p].size() > 0)
		begin
			if (resp_valid[p])
				stage_pop(p);
			next_cycle();
		end
	endtask

	// Both ports push and pop in the same cycles
	// In fill mode every port writes its whole half once
	task automatic run_traffic(input int n_cmds, input bit fill);
		int sent [NUM_PORTS];
		logic [31:0] r;
		logic [HALF_W-1:0] off;
		logic pending;
		for (int p = 0; p < NUM_PORTS; p++)
			sent[p] = 0;
		pending = 1'b1;
		while (pending)
		begin
			for (int p = 0; p < NUM_PORTS; p++)
			begin
				if (sent[p] < n_cmds && !req_full[p])
				begin
					r = lcg_next();
					// Upper bits of the generator are the well mixed ones
					off = fill ? sent[p][HALF_W-1:0] : r[30 -: HALF_W];
					stage_push(p, fill ? 1'b1 : r[31], {p[0], off}, lcg_next());
					sent[p]++;
				end
				if (resp_valid[p])
					stage_pop(p);
			end
			next_cycle();
			pending = (outstanding() > 0);
			for (int p = 0; p < NUM_PORTS; p++)
				if (sent[p] < n_cmds)
					pending = 1'b1;
		end
	endtask

	// ==============================
	// Checks
	// ==============================

	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_check
		a_resp_data: assert property (@(posedge clk) disable iff (rst)
			resp_pop[p] |-> resp_data[p] == exp_data[p])
		else
		begin
			$display("CHECK FAILED at %0t ns: resp_data[%0d] = %h, expected %h",
				$time, p, $sampled(resp_data[p]), exp_data[p]);
			stop_on_error();
		end

		// No read data can exist before the memory is calibrated
		a_valid_after_calib: assert property (@(posedge clk) disable iff (rst)
			resp_valid[p] |-> calib_complete)
		else
		begin
			$display("CHECK FAILED at %0t ns: calib_complete = %b, expected 1 with resp_valid[%0d]",
				$time, $sampled(calib_complete), p);
			stop_on_error();
		end

		a_full_seen: assert property (@(posedge clk) disable iff (rst)
			full_expect[p] |-> req_full[p])
		else
		begin
			$display("CHECK FAILED at %0t ns: req_full[%0d] = %b, expected 1",
				$time, p, $sampled(req_full[p]));
			stop_on_error();
		end

		// The full queue was built while calibration was still running
		a_queued_in_calib: assert property (@(posedge clk) disable iff (rst)
			full_expect[p] |-> !calib_complete)
		else
		begin
			$display("CHECK FAILED at %0t ns: calib_complete = %b, expected 0",
				$time, $sampled(calib_complete));
			stop_on_error();
		end

		// A response that is not popped stays in its queue
		a_resp_kept: assert property (@(posedge clk) disable iff (rst)
			(resp_valid[p] && !resp_pop[p]) |=> resp_valid[p])
		else
		begin
			$display("CHECK FAILED at %0t ns: resp_valid[%0d] = %b, expected 1",
				$time, p, $sampled(resp_valid[p]));
			stop_on_error();
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("ERROR: timeout after %0d cycles, the tests did not finish", cycle_cnt);
			stop_on_error();
		end
	end

	// ==============================
	// Stimulus
	// ==============================

	initial
	begin
		int k;
		lcg_state = 32'd56806;
		rst = 1'b1;
		req_push = '0;
		req_we = '0;
		resp_pop = '0;
		full_expect = '0;
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			req_addr[p] = '0;
			req_wdata[p] = '0;
			exp_data[p] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#10;
		rst = 1'b0;

		// Queues drop pushes until their reset window has passed
		repeat (`MPMC_FIFO_RST_CYCLES + 1) next_cycle();

		// Four commands fill the port 0 queue long before calibration ends
		stage_push(0, 1'b1, ADDR_W'(3), lcg_next());
		next_cycle();
		stage_push(0, 1'b0, ADDR_W'(3), '0);
		next_cycle();
		stage_push(0, 1'b1, ADDR_W'(9), lcg_next());
		next_cycle();
		stage_push(0, 1'b0, ADDR_W'(9), '0);
		next_cycle();
		full_expect[0] = 1'b1;
		next_cycle();
		full_expect[0] = 1'b0;
		// The fifth push waits until service starts after calibration
		push_cmd(0, 1'b0, ADDR_W'(9), '0);
		drain(0);

		// Read after write on each port where the second write to an address wins
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			for (k = 0; k < 4; k++)
			begin
				push_cmd(p, 1'b1, ADDR_W'(p * 32 + k), lcg_next());
				push_cmd(p, 1'b1, ADDR_W'(p * 32 + k), lcg_next());
				push_cmd(p, 1'b0, ADDR_W'(p * 32 + k), '0);
			end
			drain(p);
		end

		// Port 1 reads a word that port 0 wrote and read back already
		push_cmd(0, 1'b1, ADDR_W'(20), lcg_next());
		push_cmd(0, 1'b0, ADDR_W'(20), '0);
		drain(0);
		push_cmd(1, 1'b0, ADDR_W'(20), '0);
		drain(1);

		// Five reads with no pops fill the response queue and stall the sequencer
		for (k = 0; k < 5; k++)
			push_cmd(1, 1'b0, ADDR_W'(32 + k % 4), '0);
		while (!resp_valid[1])
			next_cycle();
		repeat (STALL_CYCLES) next_cycle();
		drain(1);

		// Known contents go everywhere first and random mixed traffic on both ports follows
		run_traffic(2 ** HALF_W, 1'b1);
		run_traffic(40, 1'b0);

		if (outstanding() == 0)
		begin
			$display("all tests passed");
			$finish;
		end
		else
		begin
			$display("ERROR: %0d reads never returned", outstanding());
			stop_on_error();
		end
	end

endmodule

`default_nettype wire
